// ==== src/rvPkg.sv ====
`default_nettype none

package rvPkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  regAddr_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_PASSB
   } aluOp_e;

   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_LINK
   } wbSel_e;

   typedef struct packed {
      aluOp_e     aluOp;
      logic       srcAIsPc;
      logic       srcBIsImm;
      logic       memRead;
      logic       memWrite;
      logic       isBranch;
      logic [1:0] branchKind; // {funct3[2], funct3[0]}
      logic       isJump;
      logic       isJalr;
      logic       regWrite;
      wbSel_e     wbSel;
      logic       isHalt;
      logic       valid;      // low means bubble
   } ctrl_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc;
      word_t    imm;
      regAddr_t rs1;
      regAddr_t rs2;
      regAddr_t rd;
      word_t    rs1Val;
      word_t    rs2Val;
   } decodeOut_t;

   typedef struct packed {
      ctrl_t    ctrl;
      word_t    aluResult;
      word_t    memData;
      word_t    link;
      regAddr_t rd;
      logic     branchTaken;
   } execOut_t;

   typedef struct packed {
      logic     we;
      regAddr_t addr;
      word_t    data;
   } wbBus_t;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

   localparam logic [1:0] BR_EQ = 2'd0;
   localparam logic [1:0] BR_NE = 2'd1;
   localparam logic [1:0] BR_LT = 2'd2;
   localparam logic [1:0] BR_GE = 2'd3;

   localparam word_t RESET_PC = 32'h0000_0000;

   // value an execute-to-result payload writes back
   function automatic word_t wbValue(execOut_t x);
      word_t v;
      case (x.ctrl.wbSel)
         WB_MEM:  v = x.memData;
         WB_LINK: v = x.link;
         default: v = x.aluResult;
      endcase
      return v;
   endfunction

endpackage

`default_nettype wire

// ==== src/fetchUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetchUnit (
   input  logic         CLK,
   input  logic         RSTn,
   input  logic         redirect,
   input  rvPkg::word_t target,
   input  logic         halted,
   output rvPkg::word_t pc,
   output logic [11:0]  I_MEM_ADDR,
   output logic         I_MEM_CSN
);
   import rvPkg::*;

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         pc <= RESET_PC;
      end else if (halted) begin
         pc <= pc; // frozen until reset
      end else if (redirect) begin
         pc <= target;
      end else begin
         pc <= pc + 32'd4;
      end
   end

   assign I_MEM_ADDR = pc[11:0]; // byte address
   assign I_MEM_CSN  = RSTn | halted;

endmodule

`default_nettype wire

// ==== src/decodeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
   input  rvPkg::word_t      pc,
   input  rvPkg::word_t      instr,
   input  rvPkg::word_t      rfRd1,
   input  rvPkg::word_t      rfRd2,
   input  rvPkg::wbBus_t     wb,
   output rvPkg::regAddr_t   RF_RA1,
   output rvPkg::regAddr_t   RF_RA2,
   output rvPkg::decodeOut_t dec
);
   import rvPkg::*;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   regAddr_t   rs1;
   regAddr_t   rs2;
   regAddr_t   rd;
   word_t      immI;
   word_t      immS;
   word_t      immB;
   word_t      immU;
   word_t      immJ;
   word_t      imm;
   ctrl_t      ctrl;

   assign opcode = instr[6:0];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immU = {instr[31:12], 12'b0};
   assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   assign RF_RA1 = rs1;
   assign RF_RA2 = rs2;

   always_comb begin
      ctrl = '0;
      imm  = immI;
      case (opcode)
         OPC_OP: begin
            ctrl.regWrite = 1'b1;
            ctrl.valid    = (funct7 == 7'b0) || (funct7 == 7'b0100000 && funct3 == 3'b000);
            case (funct3)
               3'b000:  ctrl.aluOp = funct7[5] ? ALU_SUB : ALU_ADD;
               3'b001:  ctrl.aluOp = ALU_SLL;
               3'b010:  ctrl.aluOp = ALU_SLT;
               3'b100:  ctrl.aluOp = ALU_XOR;
               3'b101:  ctrl.aluOp = ALU_SRL;
               3'b110:  ctrl.aluOp = ALU_OR;
               3'b111:  ctrl.aluOp = ALU_AND;
               default: ctrl.valid = 1'b0; // SLTU
            endcase
         end
         OPC_OPIMM: begin
            ctrl.regWrite  = 1'b1;
            ctrl.srcBIsImm = 1'b1;
            ctrl.valid     = 1'b1;
            case (funct3)
               3'b000:  ctrl.aluOp = ALU_ADD;
               3'b010:  ctrl.aluOp = ALU_SLT;
               3'b100:  ctrl.aluOp = ALU_XOR;
               3'b110:  ctrl.aluOp = ALU_OR;
               3'b111:  ctrl.aluOp = ALU_AND;
               default: ctrl.valid = 1'b0; // immediate shifts, SLTIU
            endcase
         end
         OPC_LUI: begin
            imm            = immU;
            ctrl.aluOp     = ALU_PASSB;
            ctrl.srcBIsImm = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.valid     = 1'b1;
         end
         OPC_LOAD: begin
            ctrl.srcBIsImm = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.wbSel     = WB_MEM;
            ctrl.valid     = (funct3 == 3'b010); // LW only
         end
         OPC_STORE: begin
            imm            = immS;
            ctrl.srcBIsImm = 1'b1;
            ctrl.memWrite  = 1'b1;
            ctrl.valid     = (funct3 == 3'b010);
         end
         OPC_BRANCH: begin
            // ALU forms the target, the compare runs beside it
            imm             = immB;
            ctrl.srcAIsPc   = 1'b1;
            ctrl.srcBIsImm  = 1'b1;
            ctrl.isBranch   = 1'b1;
            ctrl.branchKind = {funct3[2], funct3[0]};
            ctrl.valid      = (funct3[1] == 1'b0);
         end
         OPC_JAL: begin
            imm            = immJ;
            ctrl.srcAIsPc  = 1'b1;
            ctrl.srcBIsImm = 1'b1;
            ctrl.isJump    = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.wbSel     = WB_LINK;
            ctrl.valid     = 1'b1;
         end
         OPC_JALR: begin
            ctrl.srcBIsImm = 1'b1;
            ctrl.isJump    = 1'b1;
            ctrl.isJalr    = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.wbSel     = WB_LINK;
            ctrl.valid     = (funct3 == 3'b000);
         end
         OPC_SYSTEM: begin
            ctrl.isHalt = 1'b1;
            ctrl.valid  = (instr == 32'h0000_0073); // ECALL only
         end
         default: ctrl.valid = 1'b0;
      endcase
   end

   // the result stage writes at the same edge the register file is read
   always_comb begin
      dec.ctrl   = ctrl;
      dec.pc     = pc;
      dec.imm    = imm;
      dec.rs1    = rs1;
      dec.rs2    = rs2;
      dec.rd     = rd;
      dec.rs1Val = (wb.we && wb.addr != 5'd0 && wb.addr == rs1) ? wb.data : rfRd1;
      dec.rs2Val = (wb.we && wb.addr != 5'd0 && wb.addr == rs2) ? wb.data : rfRd2;
   end

endmodule

`default_nettype wire

// ==== src/pipeReg.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     CLK,
   input  logic     RSTn,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge CLK) begin
      if (RSTn || flush) begin
         q <= '0; // bubble, valid low
      end else begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

// ==== src/executeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module executeUnit (
   input  rvPkg::decodeOut_t dx,
   input  rvPkg::execOut_t   fwd,
   input  rvPkg::word_t      memRdata,
   output logic              redirect,
   output rvPkg::word_t      target,
   output logic [11:0]       D_MEM_ADDR,
   output rvPkg::word_t      D_MEM_DOUT,
   output logic              D_MEM_WEN,
   output logic              D_MEM_CSN
   ,
   output rvPkg::execOut_t   xr
);
   import rvPkg::*;

   logic  fwdOk;
   word_t fwdVal;
   word_t opA;
   word_t opB;
   word_t aluA;
   word_t aluB;
   word_t aluResult;
   logic  cond;
   logic  taken;

   // older instruction now in result
   assign fwdOk  = fwd.ctrl.valid && fwd.ctrl.regWrite && fwd.rd != 5'd0;
   assign fwdVal = wbValue(fwd);

   assign opA  = (fwdOk && fwd.rd == dx.rs1) ? fwdVal : dx.rs1Val;
   assign opB  = (fwdOk && fwd.rd == dx.rs2) ? fwdVal : dx.rs2Val;
   assign aluA = dx.ctrl.srcAIsPc ? dx.pc : opA;
   assign aluB = dx.ctrl.srcBIsImm ? dx.imm : opB;

   always_comb begin
      case (dx.ctrl.aluOp)
         ALU_ADD:   aluResult = aluA + aluB;
         ALU_SUB:   aluResult = aluA - aluB;
         ALU_AND:   aluResult = aluA & aluB;
         ALU_OR:    aluResult = aluA | aluB;
         ALU_XOR:   aluResult = aluA ^ aluB;
         ALU_SLT:   aluResult = {31'b0, $signed(aluA) < $signed(aluB)};
         ALU_SLL:   aluResult = aluA << aluB[4:0];
         ALU_SRL:   aluResult = aluA >> aluB[4:0];
         ALU_PASSB: aluResult = aluB;
         default:   aluResult = '0;
      endcase
   end

   always_comb begin
      case (dx.ctrl.branchKind)
         BR_EQ:   cond = (opA == opB);
         BR_NE:   cond = (opA != opB);
         BR_LT:   cond = ($signed(opA) < $signed(opB));
         default: cond = ($signed(opA) >= $signed(opB));
      endcase
   end

   assign taken = dx.ctrl.valid && dx.ctrl.isBranch && cond;

   // ECALL refetches itself so nothing younger gets to execute before HALT
   assign redirect = taken || (dx.ctrl.valid && (dx.ctrl.isJump || dx.ctrl.isHalt));

   always_comb begin
      if (dx.ctrl.isHalt) begin
         target = dx.pc;
      end else if (dx.ctrl.isJalr) begin
         target = {aluResult[31:1], 1'b0};
      end else begin
         target = aluResult; // pc + imm
      end
   end

   assign D_MEM_ADDR = aluResult[13:2]; // word address
   assign D_MEM_DOUT = opB;
   assign D_MEM_WEN  = ~(dx.ctrl.valid && dx.ctrl.memWrite);
   assign D_MEM_CSN  = ~(dx.ctrl.valid && (dx.ctrl.memRead || dx.ctrl.memWrite));

   always_comb begin
      xr.ctrl        = dx.ctrl;
      xr.aluResult   = aluResult;
      xr.memData     = memRdata; // read data is back within the cycle
      xr.link        = dx.pc + 32'd4;
      xr.rd          = dx.rd;
      xr.branchTaken = taken;
   end

endmodule

`default_nettype wire

// ==== src/resultUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module resultUnit (
   input  logic            CLK,
   input  logic            RSTn,
   input  rvPkg::execOut_t xr,
   output rvPkg::wbBus_t   wb,
   output logic            HALT,
   output rvPkg::word_t    NUM_INST,
   output rvPkg::word_t    OUTPUT_PORT
);
   import rvPkg::*;

   word_t wbData;

   assign wbData = wbValue(xr);

   always_comb begin
      wb.we   = xr.ctrl.valid && xr.ctrl.regWrite;
      wb.addr = xr.rd;
      wb.data = wbData;
   end

   always_ff @(posedge CLK) begin
      if (RSTn) begin
         HALT     <= 1'b0;
         NUM_INST <= '0;
      end else begin
         if (xr.ctrl.valid && xr.ctrl.isHalt) begin
            HALT <= 1'b1;
         end
         // the refetched ECALL arrives after HALT and is not counted
         if (xr.ctrl.valid && !HALT) begin
            NUM_INST <= NUM_INST + 32'd1;
         end
      end
   end

   always_comb begin
      if (!xr.ctrl.valid) begin
         OUTPUT_PORT = '0;
      end else if (xr.ctrl.regWrite) begin
         OUTPUT_PORT = wbData;
      end else if (xr.ctrl.memWrite) begin
         OUTPUT_PORT = xr.aluResult; // store byte address
      end else if (xr.ctrl.isBranch) begin
         OUTPUT_PORT = {31'b0, xr.branchTaken};
      end else begin
         OUTPUT_PORT = '0;
      end
   end

endmodule

`default_nettype wire

// ==== src/rvPipeTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvPipeTop (
   input  logic            CLK,
   input  logic            RSTn,
   output logic            I_MEM_CSN,
   input  rvPkg::word_t    I_MEM_DI,
   output logic [11:0]     I_MEM_ADDR,
   output logic            D_MEM_CSN,
   input  rvPkg::word_t    D_MEM_DI,
   output rvPkg::word_t    D_MEM_DOUT,
   output logic [11:0]     D_MEM_ADDR,
   output logic            D_MEM_WEN,
   output logic            RF_WE,
   output rvPkg::regAddr_t RF_RA1,
   output rvPkg::regAddr_t RF_RA2,
   output rvPkg::regAddr_t RF_WA1,
   input  rvPkg::word_t    RF_RD1,
   input  rvPkg::word_t    RF_RD2,
   output rvPkg::word_t    RF_WD,
   output logic            HALT,
   output rvPkg::word_t    NUM_INST,
   output rvPkg::word_t    OUTPUT_PORT
);
   import rvPkg::*;

   word_t      pc;
   word_t      target;
   logic       redirect;
   logic       dxFlush;
   decodeOut_t dec;
   decodeOut_t dx;
   execOut_t   xrD;
   execOut_t   xrQ;
   wbBus_t     wb;

   assign dxFlush = redirect | HALT; // fetched words are not valid once halted
   assign RF_WE   = wb.we;
   assign RF_WA1  = wb.addr;
   assign RF_WD   = wb.data;

   fetchUnit fetch0 (.CLK(CLK), .RSTn(RSTn), .redirect(redirect), .target(target),
      .halted(HALT), .pc(pc), .I_MEM_ADDR(I_MEM_ADDR), .I_MEM_CSN(I_MEM_CSN));

   decodeUnit decode0 (.pc(pc), .instr(I_MEM_DI), .rfRd1(RF_RD1), .rfRd2(RF_RD2),
      .wb(wb), .RF_RA1(RF_RA1), .RF_RA2(RF_RA2), .dec(dec));

   pipeReg #(.payload_t(decodeOut_t)) dxReg (.CLK(CLK), .RSTn(RSTn), .flush(dxFlush),
      .d(dec), .q(dx));

   executeUnit execute0 (.dx(dx), .fwd(xrQ), .memRdata(D_MEM_DI), .redirect(redirect),
      .target(target), .D_MEM_ADDR(D_MEM_ADDR), .D_MEM_DOUT(D_MEM_DOUT),
      .D_MEM_WEN(D_MEM_WEN), .D_MEM_CSN(D_MEM_CSN), .xr(xrD));

   pipeReg #(.payload_t(execOut_t)) xrReg (.CLK(CLK), .RSTn(RSTn), .flush(1'b0),
      .d(xrD), .q(xrQ));

   resultUnit result0 (.CLK(CLK), .RSTn(RSTn), .xr(xrQ), .wb(wb), .HALT(HALT),
      .NUM_INST(NUM_INST), .OUTPUT_PORT(OUTPUT_PORT));

endmodule

`default_nettype wire

// ==== test/tbPrograms.svh ====
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// hand assembled programs, expected state once ECALL has halted the core
typedef struct packed {
   word_t [0:15] prog;     // word i sits at byte address 4*i
   word_t [0:3]  dataInit; // data words 0 to 3
   word_t [1:15] expReg;
   logic [11:0]  memAddr;  // word address
   word_t        memVal;
   word_t        expOut;   // OUTPUT_PORT of the instruction ahead of ECALL
   word_t        expCount;
} testCase_t;

localparam int NUM_TESTS = 4;

string testNames [NUM_TESTS] = '{"aluOps", "forwarding", "loadStore", "controlFlow"};

localparam testCase_t TESTS [NUM_TESTS] = '{
   // addi, lui, the register ops, the immediate ops
   '{prog: '{32'h00C00093, 32'hFFB00113, 32'h123451B7, 32'h00208233,
             32'h402082B3, 32'h0021F333, 32'h0020E3B3, 32'h0020C433,
             32'h001124B3, 32'h00909533, 32'h001155B3, 32'h0F017613,
             32'h3000E693, 32'hFFF0C713, 32'hFFC12793, 32'h00000073},
     dataInit: '{32'h0, 32'h0, 32'h0, 32'h0},
     expReg: '{32'h0000000C, 32'hFFFFFFFB, 32'h12345000, 32'h00000007, 32'h00000011,
               32'h12345000, 32'hFFFFFFFF, 32'hFFFFFFF7, 32'h00000001, 32'h00000018,
               32'h000FFFFF, 32'h000000F0, 32'h0000030C, 32'hFFFFFFF3, 32'h00000001},
     memAddr: 12'd0, memVal: 32'h0, expOut: 32'h1, expCount: 32'd16},
   // chains at distance one and two, a write to x0 in between
   // x15 marker sits right after ECALL
   '{prog: '{32'h00100093, 32'h00208113, 32'h001101B3, 32'h00318233,
             32'h402202B3, 32'h00428333, 32'h00A08093, 32'h006083B3,
             32'h0013C433, 32'h00840033, 32'h008004B3, 32'h00000073,
             32'h00100793, 32'h0, 32'h0, 32'h0},
     dataInit: '{32'h0, 32'h0, 32'h0, 32'h0},
     expReg: '{32'h0000000B, 32'h00000003, 32'h00000004, 32'h00000008, 32'h00000005,
               32'h0000000D, 32'h00000018, 32'h00000013, 32'h00000013, 32'h0,
               32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
     memAddr: 12'd0, memVal: 32'h0, expOut: 32'h13, expCount: 32'd12},
   // store then load back, load data used right away
   '{prog: '{32'h00800093, 32'hABCDE137, 32'h12310113, 32'h0020A223,
             32'h0040A183, 32'h00318233, 32'hFF80A283, 32'h0050A023,
             32'h0000A303, 32'hFE40AE23, 32'h00000073, 32'h0,
             32'h0, 32'h0, 32'h0, 32'h0},
     dataInit: '{32'h11111111, 32'h22222222, 32'h33333333, 32'h44444444},
     expReg: '{32'h00000008, 32'hABCDE123, 32'hABCDE123, 32'h579BC246, 32'h11111111,
               32'h11111111, 32'h0, 32'h0, 32'h0, 32'h0,
               32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
     memAddr: 12'd3, memVal: 32'hABCDE123, expOut: 32'h4, expCount: 32'd11},
   // beq/bge taken, bne/blt not, jal, jalr; x10 to x14 are markers
   '{prog: '{32'h00500093, 32'h00500113, 32'h00208463, 32'h00100513,
             32'h00209463, 32'h00300193, 32'h0030C463, 32'h0030D463,
             32'h00100593, 32'h00C0026F, 32'h00100613, 32'h00100693,
             32'h011202E7, 32'h00100713, 32'h00128313, 32'h00000073},
     dataInit: '{32'h0, 32'h0, 32'h0, 32'h0},
     expReg: '{32'h00000005, 32'h00000005, 32'h00000003, 32'h00000028, 32'h00000034,
               32'h00000035, 32'h0, 32'h0, 32'h0, 32'h0,
               32'h0, 32'h0, 32'h0, 32'h0, 32'h0},
     memAddr: 12'd0, memVal: 32'h0, expOut: 32'h35, expCount: 32'd11}
};

`endif

// ==== test/rvPipeTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvPipeTb;
   import rvPkg::*;

   `include "tbPrograms.svh"

   localparam int HALT_TIMEOUT = 300;

   logic        CLK;
   logic        RSTn;
   logic        I_MEM_CSN;
   word_t       I_MEM_DI;
   logic [11:0] I_MEM_ADDR;
   logic        D_MEM_CSN;
   word_t       D_MEM_DI;
   word_t       D_MEM_DOUT;
   logic [11:0] D_MEM_ADDR;
   logic        D_MEM_WEN;
   logic        RF_WE;
   regAddr_t    RF_RA1;
   regAddr_t    RF_RA2;
   regAddr_t    RF_WA1;
   word_t       RF_RD1;
   word_t       RF_RD2;
   word_t       RF_WD;
   logic        HALT;
   word_t       NUM_INST;
   word_t       OUTPUT_PORT;

   word_t imem [0:1023];
   word_t dmem [0:4095];
   word_t regs [0:31];

   int    errors;
   int    checks;
   word_t outLast;
   word_t outBefore; // result slot just ahead of ECALL

   rvPipeTop dut0 (.CLK(CLK), .RSTn(RSTn),
      .I_MEM_CSN(I_MEM_CSN), .I_MEM_DI(I_MEM_DI), .I_MEM_ADDR(I_MEM_ADDR),
      .D_MEM_CSN(D_MEM_CSN), .D_MEM_DI(D_MEM_DI), .D_MEM_DOUT(D_MEM_DOUT),
      .D_MEM_ADDR(D_MEM_ADDR), .D_MEM_WEN(D_MEM_WEN),
      .RF_WE(RF_WE), .RF_RA1(RF_RA1), .RF_RA2(RF_RA2), .RF_WA1(RF_WA1),
      .RF_RD1(RF_RD1), .RF_RD2(RF_RD2), .RF_WD(RF_WD),
      .HALT(HALT), .NUM_INST(NUM_INST), .OUTPUT_PORT(OUTPUT_PORT));

   // reads answer within the cycle
   assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
   assign D_MEM_DI = dmem[D_MEM_ADDR];
   assign RF_RD1   = regs[RF_RA1];
   assign RF_RD2   = regs[RF_RA2];

   always @(posedge CLK) begin
      if (!D_MEM_CSN && !D_MEM_WEN) begin
         dmem[D_MEM_ADDR] <= D_MEM_DOUT;
      end
      if (RF_WE && RF_WA1 != 5'd0) begin
         regs[RF_WA1] <= RF_WD; // x0 stays zero
      end
   end

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic checkCount(input string name, input word_t expected, input word_t actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic checkFlag(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   task automatic loadProgram(input int t);
      for (int i = 0; i < 1024; i++) begin
         imem[i] = (i < 16) ? TESTS[t].prog[i] : '0;
      end
      for (int i = 0; i < 4096; i++) begin
         dmem[i] = (i < 4) ? TESTS[t].dataInit[i] : '0;
      end
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
   endtask

   task automatic resetCore(input int t);
      RSTn = 1'b1;
      repeat (2) @(negedge CLK);
      checkFlag({testNames[t], " reset RF_WE"}, 1'b0, RF_WE);
      checkFlag({testNames[t], " reset D_MEM_WEN"}, 1'b1, D_MEM_WEN);
      checkFlag({testNames[t], " reset D_MEM_CSN"}, 1'b1, D_MEM_CSN);
      checkFlag({testNames[t], " reset I_MEM_CSN"}, 1'b1, I_MEM_CSN);
      checkFlag({testNames[t], " reset HALT"}, 1'b0, HALT);
      checkCount({testNames[t], " reset NUM_INST"}, '0, NUM_INST);
      RSTn = 1'b0;
   endtask

   task automatic waitForHalt(input int t, output logic halted);
      int cycles;
      cycles    = 0;
      outLast   = '0;
      outBefore = '0;
      while (HALT !== 1'b1 && cycles < HALT_TIMEOUT) begin
         @(negedge CLK);
         cycles++;
         if (HALT !== 1'b1) begin
            outBefore = outLast;
            outLast   = OUTPUT_PORT;
         end
      end
      halted = (HALT === 1'b1);
      if (!halted) begin
         errors++;
         $display("%s: HALT did not rise within %0d cycles", testNames[t], HALT_TIMEOUT);
      end
   endtask

   task automatic checkResults(input int t);
      repeat (4) @(negedge CLK); // anything fetched past ECALL would have retired by now
      for (int r = 1; r < 16; r++) begin
         checkWord($sformatf("%s x%0d", testNames[t], r), TESTS[t].expReg[r], regs[r]);
      end
      checkWord({testNames[t], " data word"}, TESTS[t].memVal, dmem[TESTS[t].memAddr]);
      checkWord({testNames[t], " OUTPUT_PORT"}, TESTS[t].expOut, outBefore);
      checkFlag({testNames[t], " HALT held"}, 1'b1, HALT);
      checkFlag({testNames[t], " I_MEM_CSN after halt"}, 1'b1, I_MEM_CSN);
      checkCount({testNames[t], " NUM_INST"}, TESTS[t].expCount, NUM_INST);
   endtask

   initial begin
      logic halted;
      RSTn   = 1'b1;
      errors = 0;
      checks = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         loadProgram(t);
         resetCore(t);
         waitForHalt(t, halted);
         if (halted) begin
            checkResults(t);
         end
      end
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== rvPipe.f ====
+incdir+test
src/rvPkg.sv
src/fetchUnit.sv
src/decodeUnit.sv
src/pipeReg.sv
src/executeUnit.sv
src/resultUnit.sv
src/rvPipeTop.sv
test/rvPipeTb.sv
